/* flist.f */
rv_ctrl_pkg.sv
alu_decode.sv
branch_resolve.sv
operand_forward.sv
wb_decode.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_pipe_ctrl with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module tb_pipe_ctrl -Mdir obj_dir
	./obj_dir/Vtb_pipe_ctrl

clean:
	rm -rf obj_dir

/* tb_pipe_ctrl.sv */
module tb_pipe_ctrl;
  import rv_ctrl_pkg::*;

  localparam int          MAX_CYCLES = 20000;
  localparam int          MIN_HITS   = 5;
  localparam logic [15:0] LFSR_TAPS  = 16'hB400;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] d_instr;
  logic            br_eq;
  logic            br_lt;
  logic            br_pred_taken;
  alu_op_e         alu_sel;
  logic            b_sel;
  logic            br_un;
  logic            br_taken;
  pc_sel_e         pc_sel;
  logic            nop_sel;
  fwd_sel_e        fwd_a_sel;
  fwd_sel_e        fwd_b_sel;
  fwd_sel_e        rs2_sel;
  a_sel_e          a_sel;
  logic            rf_we;
  wb_sel_e         wb_sel;
  ldx_sel_e        ldx_sel;

  logic [XLEN-1:0] x_m;         // Word the DUT holds in X
  logic [XLEN-1:0] wf_m;        // Word the DUT holds in WF
  logic            prev_rst;
  logic            last_flush;  // Flush seen at the previous edge
  logic [15:0]     lfsr;
  int              hits [6];    // Flush, jal, mem fwd, alu fwd, a_mem, store fwd
  opcode_e         opc_tab [9] = '{OPC_ARI_RTYPE, OPC_ARI_ITYPE, OPC_LOAD, OPC_STORE,
                                   OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_AUIPC, OPC_LUI};

  pipe_ctrl_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic is_op(input logic [XLEN-1:0] w, input opcode_e o);
    return (w[1:0] == 2'b11) && (w[6:2] == o);  // Bubble has low bits 00
  endfunction

  function automatic alu_op_e alu_op_of(input logic [XLEN-1:0] w);
    logic    rtype;
    alu_op_e op;
    rtype = is_op(w, OPC_ARI_RTYPE);
    op    = is_op(w, OPC_LUI) ? ALU_PASS_B : ALU_ADD;
    if (rtype || is_op(w, OPC_ARI_ITYPE)) begin
      case (w[14:12])
        3'b000:  op = (rtype && w[30]) ? ALU_SUB : ALU_ADD;
        3'b001:  op = ALU_SLL;
        3'b010:  op = ALU_SLT;
        3'b011:  op = ALU_SLTU;
        3'b100:  op = ALU_XOR;
        3'b101:  op = w[30] ? ALU_SRA : ALU_SRL;
        3'b110:  op = ALU_OR;
        default: op = ALU_AND;
      endcase
    end
    return op;
  endfunction

  function automatic logic taken_of(input logic [XLEN-1:0] w, input logic eq, input logic lt);
    logic t;
    case (w[14:12])
      3'b000:         t = eq;
      3'b001:         t = !eq;
      3'b100, 3'b110: t = lt;   // blt, bltu
      3'b101, 3'b111: t = !lt;  // bge, bgeu
      default:        t = 1'b0;
    endcase
    return is_op(w, OPC_BRANCH) && t;
  endfunction

  // Redirect priority, highest first
  function automatic pc_sel_e next_pc_of(input logic r, input logic [XLEN-1:0] x,
                                         input logic [XLEN-1:0] d, input logic eq,
                                         input logic lt, input logic pred);
    logic    br;
    logic    t;
    pc_sel_e pc;
    br = is_op(x, OPC_BRANCH);
    t  = taken_of(x, eq, lt);
    if (r) pc = PC_RESET;
    else if (is_op(x, OPC_JALR)) pc = PC_ALU;
    else if (br && t && !pred) pc = PC_ALU;
    else if (br && !t && pred) pc = PC_X_SEQ;
    else if (is_op(d, OPC_JAL)) pc = PC_JAL;
    else pc = PC_SEQ;
    return pc;
  endfunction

  function automatic fwd_sel_e fwd_of(input logic [REG_AW-1:0] src, input logic [XLEN-1:0] wf);
    logic     prod;
    fwd_sel_e f;
    prod = (wf[1:0] == 2'b11) && (wf[11:7] != '0)
           && !is_op(wf, OPC_STORE) && !is_op(wf, OPC_BRANCH);
    if (!prod || (wf[11:7] != src)) f = FWD_REG;
    else if (is_op(wf, OPC_LOAD)) f = FWD_MEM;
    else f = FWD_ALU;
    return f;
  endfunction

  function automatic fwd_sel_e store_src_of(input logic [XLEN-1:0] x, input logic [XLEN-1:0] wf);
    return is_op(x, OPC_STORE) ? fwd_of(x[24:20], wf) : FWD_REG;
  endfunction

  function automatic a_sel_e a_src_of(input logic [XLEN-1:0] x, input logic [XLEN-1:0] wf);
    a_sel_e a;
    if (is_op(x, OPC_BRANCH) || is_op(x, OPC_JAL) || is_op(x, OPC_AUIPC)) a = A_PC;
    else if (is_op(x, OPC_STORE) && (fwd_of(x[19:15], wf) == FWD_MEM)) a = A_MEM;
    else a = A_REG;
    return a;
  endfunction

  function automatic logic writes_rf(input logic [XLEN-1:0] w);
    return is_op(w, OPC_ARI_RTYPE) || is_op(w, OPC_ARI_ITYPE) || is_op(w, OPC_LOAD)
           || is_op(w, OPC_JAL) || is_op(w, OPC_JALR) || is_op(w, OPC_AUIPC)
           || is_op(w, OPC_LUI);
  endfunction

  function automatic wb_sel_e wb_src_of(input logic [XLEN-1:0] w);
    wb_sel_e s;
    if (is_op(w, OPC_LOAD)) s = WB_MEM;
    else if (is_op(w, OPC_JAL) || is_op(w, OPC_JALR)) s = WB_PC4;
    else s = WB_ALU;
    return s;
  endfunction

  function automatic ldx_sel_e load_ext_of(input logic [XLEN-1:0] w);
    ldx_sel_e e;
    case (w[14:12])
      3'b000:  e = LX_B;
      3'b001:  e = LX_H;
      3'b100:  e = LX_BU;
      3'b101:  e = LX_HU;
      default: e = LX_W;
    endcase
    return is_op(w, OPC_LOAD) ? e : LX_W;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  // Registers x0..x3 only, so dependences are common
  task automatic make_word(output logic [XLEN-1:0] w);
    logic [31:0] idx;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] alt;
    logic [3:0]  sel;
    draw(4, idx);
    draw(2, rd);
    draw(2, rs1);
    draw(2, rs2);
    draw(3, f3);
    draw(1, alt);
    sel = 4'(idx % 9);
    w   = {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_tab[sel], 2'b11};
  endtask

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  // Updates the model with what the last rising edge latched, then drives
  task automatic step(input logic rst_v);
    pc_sel_e     pc_e;
    logic [31:0] v;
    @(negedge clk);
    pc_e       = next_pc_of(rst, x_m, d_instr, br_eq, br_lt, br_pred_taken);
    last_flush = !rst && ((pc_e == PC_ALU) || (pc_e == PC_X_SEQ));
    prev_rst   = rst;
    wf_m       = rst ? '0 : x_m;
    x_m        = (rst || last_flush) ? '0 : d_instr;
    if (last_flush) hits[0]++;
    if (pc_e == PC_JAL) hits[1]++;
    if (fwd_of(x_m[19:15], wf_m) == FWD_MEM) hits[2]++;
    if (fwd_of(x_m[24:20], wf_m) == FWD_ALU) hits[3]++;
    if (a_src_of(x_m, wf_m) == A_MEM) hits[4]++;
    if (store_src_of(x_m, wf_m) != FWD_REG) hits[5]++;
    rst = rst_v;
    make_word(v);
    d_instr = v;
    draw(3, v);
    {br_eq, br_lt, br_pred_taken} = v[2:0];
  endtask

  a_reset_pc: assert property (@(posedge clk) rst |-> (pc_sel == PC_RESET))
    else fail_run($sformatf("ERROR %0t: pc_sel %0d during reset", $time, pc_sel));

  a_reset_exit: assert property (@(posedge clk) (prev_rst && !rst) |-> (!rf_we && !nop_sel))
    else fail_run($sformatf("ERROR %0t: rf_we %b nop_sel %b after reset", $time, rf_we, nop_sel));

  a_alu: assert property (@(posedge clk) disable iff (rst)
    (alu_sel == alu_op_of(x_m)) && (b_sel == ((x_m[1:0] == 2'b11) && !is_op(x_m, OPC_ARI_RTYPE)))
    && (br_un == (is_op(x_m, OPC_BRANCH) && (x_m[14:13] == 2'b11))))
    else fail_run($sformatf("ERROR %0t: X %h alu_sel %0d b_sel %b br_un %b",
                            $time, x_m, alu_sel, b_sel, br_un));

  a_branch: assert property (@(posedge clk) disable iff (rst)
    (br_taken == taken_of(x_m, br_eq, br_lt))
    && (pc_sel == next_pc_of(1'b0, x_m, d_instr, br_eq, br_lt, br_pred_taken))
    && (nop_sel == (next_pc_of(1'b0, x_m, d_instr, br_eq, br_lt, br_pred_taken)
                    inside {PC_ALU, PC_X_SEQ})))
    else fail_run($sformatf("ERROR %0t: X %h D %h br_taken %b pc_sel %0d nop_sel %b",
                            $time, x_m, d_instr, br_taken, pc_sel, nop_sel));

  // Bubble in X after a flush
  a_bubble: assert property (@(posedge clk) disable iff (rst)
    last_flush |-> ((alu_sel == ALU_ADD) && !b_sel && !br_un && !br_taken && !nop_sel))
    else fail_run($sformatf("ERROR %0t: X controls active after flush", $time));

  a_fwd: assert property (@(posedge clk) disable iff (rst)
    (fwd_a_sel == fwd_of(x_m[19:15], wf_m)) && (fwd_b_sel == fwd_of(x_m[24:20], wf_m))
    && (rs2_sel == store_src_of(x_m, wf_m)) && (a_sel == a_src_of(x_m, wf_m)))
    else fail_run($sformatf("ERROR %0t: X %h WF %h fwd %0d %0d rs2 %0d a_sel %0d",
                            $time, x_m, wf_m, fwd_a_sel, fwd_b_sel, rs2_sel, a_sel));

  a_wb: assert property (@(posedge clk) disable iff (rst)
    (rf_we == writes_rf(wf_m)) && (wb_sel == wb_src_of(wf_m)) && (ldx_sel == load_ext_of(wf_m)))
    else fail_run($sformatf("ERROR %0t: WF %h rf_we %b wb_sel %0d ldx_sel %0d",
                            $time, wf_m, rf_we, wb_sel, ldx_sel));

  initial begin : main_seq
    int   cyc;
    logic done;
    rst           = 1'b1;
    d_instr       = BUBBLE_INSTR;
    br_eq         = 1'b0;
    br_lt         = 1'b0;
    br_pred_taken = 1'b0;
    x_m           = '0;
    wf_m          = '0;
    prev_rst      = 1'b1;
    last_flush    = 1'b0;
    lfsr          = 16'd8034;
    foreach (hits[i]) hits[i] = 0;
    repeat (8) step(1'b1);
    cyc  = 0;
    done = 1'b0;
    // Run until every case has been hit a few times
    while (!done && (cyc < MAX_CYCLES)) begin
      step(1'b0);
      cyc++;
      done = 1'b1;
      foreach (hits[i]) begin
        if (hits[i] < MIN_HITS) done = 1'b0;
      end
    end
    @(negedge clk);
    if (done) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_run($sformatf("Timeout: stimulus did not reach every case within %0d cycles",
                         MAX_CYCLES));
    end
  end

endmodule

/* pipe_ctrl_top.sv */
module pipe_ctrl_top import rv_ctrl_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] d_instr,
  input  logic            br_eq,
  input  logic            br_lt,
  input  logic            br_pred_taken,
  output alu_op_e         alu_sel,
  output logic            b_sel,
  output logic            br_un,
  output logic            br_taken,
  output pc_sel_e         pc_sel,
  output logic            nop_sel,
  output fwd_sel_e        fwd_a_sel,
  output fwd_sel_e        fwd_b_sel,
  output fwd_sel_e        rs2_sel,
  output a_sel_e          a_sel,
  output logic            rf_we,
  output wb_sel_e         wb_sel,
  output ldx_sel_e        ldx_sel
);

  logic [XLEN-1:0] x_instr;
  logic [XLEN-1:0] wf_instr;

  // D, X and WF each hold one word
  always_ff @(posedge clk) begin
    if (rst) begin
      x_instr  <= BUBBLE_INSTR;
      wf_instr <= BUBBLE_INSTR;
    end else begin
      x_instr  <= nop_sel ? BUBBLE_INSTR : d_instr;  // Kill the wrong-path word
      wf_instr <= x_instr;
    end
  end

  alu_decode u_alu_decode (
    .x_instr (x_instr),
    .alu_sel (alu_sel),
    .b_sel   (b_sel),
    .br_un   (br_un)
  );

  branch_resolve u_branch_resolve (
    .clk           (clk),
    .rst           (rst),
    .d_instr       (d_instr),
    .x_instr       (x_instr),
    .br_eq         (br_eq),
    .br_lt         (br_lt),
    .br_pred_taken (br_pred_taken),
    .br_taken      (br_taken),
    .pc_sel        (pc_sel),
    .nop_sel       (nop_sel)
  );

  operand_forward u_operand_forward (
    .x_instr   (x_instr),
    .wf_instr  (wf_instr),
    .fwd_a_sel (fwd_a_sel),
    .fwd_b_sel (fwd_b_sel),
    .rs2_sel   (rs2_sel),
    .a_sel     (a_sel)
  );

  wb_decode u_wb_decode (
    .wf_instr (wf_instr),
    .rf_we    (rf_we),
    .wb_sel   (wb_sel),
    .ldx_sel  (ldx_sel)
  );

  // A bubble in X cannot redirect again
  a_flush_once: assert property (@(posedge clk) disable iff (rst)
    nop_sel |=> !nop_sel)
    else $error("pipe_ctrl_top: back-to-back flush");

endmodule

/* wb_decode.sv */
module wb_decode import rv_ctrl_pkg::*; (
  input  logic [XLEN-1:0] wf_instr,
  output logic            rf_we,
  output wb_sel_e         wb_sel,
  output ldx_sel_e        ldx_sel   // Load byte/half extension
);

  opcode_e opc;
  logic    opc_ok;

  assign opc    = instr_opc(wf_instr);
  assign opc_ok = instr_ok(wf_instr);

  always_comb begin
    rf_we   = 1'b0;
    wb_sel  = WB_ALU;
    ldx_sel = LX_W;
    if (opc_ok) begin
      case (opc)
        OPC_ARI_RTYPE, OPC_ARI_ITYPE, OPC_AUIPC, OPC_LUI: begin
          rf_we = 1'b1;
        end
        OPC_LOAD: begin
          rf_we  = 1'b1;
          wb_sel = WB_MEM;
          case (instr_funct3(wf_instr))
            FNC_LB:  ldx_sel = LX_B;
            FNC_LBU: ldx_sel = LX_BU;
            FNC_LH:  ldx_sel = LX_H;
            FNC_LHU: ldx_sel = LX_HU;
            default: ldx_sel = LX_W;  // lw and reserved codes
          endcase
        end
        OPC_JAL, OPC_JALR: begin
          rf_we  = 1'b1;
          wb_sel = WB_PC4;  // Link address
        end
        default: begin
          rf_we = 1'b0;  // Stores, branches
        end
      endcase
    end
  end

endmodule

/* operand_forward.sv */
module operand_forward import rv_ctrl_pkg::*; (
  input  logic [XLEN-1:0] x_instr,
  input  logic [XLEN-1:0] wf_instr,
  output fwd_sel_e        fwd_a_sel,
  output fwd_sel_e        fwd_b_sel,
  output fwd_sel_e        rs2_sel,    // Store data source
  output a_sel_e          a_sel
);

  opcode_e           x_opc;
  opcode_e           wf_opc;
  logic              x_ok;
  logic              wf_ok;
  logic [REG_AW-1:0] wf_rd;
  logic [REG_AW-1:0] x_rs1;
  logic [REG_AW-1:0] x_rs2;
  logic              wf_prod;  // WF will write a nonzero rd
  logic              wf_load;
  logic              hit_rs1;
  logic              hit_rs2;
  logic              x_store;
  logic              x_pc_op;  // Operand A is the X pc

  assign x_opc  = instr_opc(x_instr);
  assign wf_opc = instr_opc(wf_instr);
  assign x_ok   = instr_ok(x_instr);
  assign wf_ok  = instr_ok(wf_instr);
  assign wf_rd  = instr_rd(wf_instr);
  assign x_rs1  = instr_rs1(x_instr);
  assign x_rs2  = instr_rs2(x_instr);

  assign wf_prod = wf_ok && (wf_rd != '0)
                   && (wf_opc != OPC_STORE) && (wf_opc != OPC_BRANCH);
  assign wf_load = wf_prod && (wf_opc == OPC_LOAD);

  assign hit_rs1 = wf_prod && (wf_rd == x_rs1);
  assign hit_rs2 = wf_prod && (wf_rd == x_rs2);

  assign x_store = x_ok && (x_opc == OPC_STORE);
  assign x_pc_op = x_ok && ((x_opc == OPC_BRANCH) || (x_opc == OPC_JAL)
                            || (x_opc == OPC_AUIPC));

  function automatic fwd_sel_e fwd_src(input logic hit, input logic load);
    fwd_sel_e src;
    if (!hit) src = FWD_REG;
    else if (load) src = FWD_MEM;  // Load data is ready only at WF
    else src = FWD_ALU;
    return src;
  endfunction

  assign fwd_a_sel = fwd_src(hit_rs1, wf_load);
  assign fwd_b_sel = fwd_src(hit_rs2, wf_load);

  always_comb begin
    rs2_sel = FWD_REG;
    if (x_store) rs2_sel = fwd_src(hit_rs2, wf_load);
  end

  // Load then store on the same base register
  always_comb begin
    if (x_pc_op) a_sel = A_PC;
    else if (x_store && wf_load && hit_rs1) a_sel = A_MEM;
    else a_sel = A_REG;
  end

endmodule

/* branch_resolve.sv */
module branch_resolve import rv_ctrl_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] d_instr,
  input  logic [XLEN-1:0] x_instr,
  input  logic            br_eq,
  input  logic            br_lt,
  input  logic            br_pred_taken,  // Static guess for the X branch
  output logic            br_taken,
  output pc_sel_e         pc_sel,
  output logic            nop_sel         // Flush the word in D
);

  logic x_branch;
  logic x_jalr;
  logic d_jal;
  logic miss_taken;  // Taken but guessed not taken
  logic miss_fall;   // Fell through but guessed taken

  assign x_branch = instr_ok(x_instr) && (instr_opc(x_instr) == OPC_BRANCH);
  assign x_jalr   = instr_ok(x_instr) && (instr_opc(x_instr) == OPC_JALR);
  assign d_jal    = instr_ok(d_instr) && (instr_opc(d_instr) == OPC_JAL);

  always_comb begin
    br_taken = 1'b0;
    if (x_branch) begin
      case (instr_funct3(x_instr))
        FNC_BEQ:           br_taken = br_eq;
        FNC_BNE:           br_taken = !br_eq;
        FNC_BLT, FNC_BLTU: br_taken = br_lt;   // Signedness set by br_un
        FNC_BGE, FNC_BGEU: br_taken = !br_lt;
        default:           br_taken = 1'b0;
      endcase
    end
  end

  assign miss_taken = x_branch && br_taken && !br_pred_taken;
  assign miss_fall  = x_branch && !br_taken && br_pred_taken;

  // X redirects win over the D jump
  always_comb begin
    if (rst) pc_sel = PC_RESET;
    else if (x_jalr || miss_taken) pc_sel = PC_ALU;
    else if (miss_fall) pc_sel = PC_X_SEQ;
    else if (d_jal) pc_sel = PC_JAL;
    else pc_sel = PC_SEQ;
  end

  assign nop_sel = !rst && (x_jalr || miss_taken || miss_fall);

  // The word behind a redirect never reaches X
  a_flush_clears_x: assert property (@(posedge clk) disable iff (rst)
    nop_sel |=> !(x_branch || x_jalr))
    else $error("branch_resolve: branch or jalr in X right after a flush");

endmodule

/* alu_decode.sv */
module alu_decode import rv_ctrl_pkg::*; (
  input  logic [XLEN-1:0] x_instr,
  output alu_op_e         alu_sel,
  output logic            b_sel,   // Operand B is the immediate
  output logic            br_un    // Unsigned branch compare
);

  opcode_e    opc;
  logic       opc_ok;
  logic [2:0] funct3;
  logic       bit30;

  assign opc    = instr_opc(x_instr);
  assign opc_ok = instr_ok(x_instr);
  assign funct3 = instr_funct3(x_instr);
  assign bit30  = x_instr[30];

  // Bit 30 picks sub for R-type only
  function automatic alu_op_e arith_op(input logic [2:0] f3,
                                       input logic       alt,
                                       input logic       rtype);
    alu_op_e op;
    case (f3)
      FNC_ADD_SUB: begin
        if (rtype && alt == FNC7_SUB) op = ALU_SUB;
        else op = ALU_ADD;
      end
      FNC_SLL:     op = ALU_SLL;
      FNC_SLT:     op = ALU_SLT;
      FNC_SLTU:    op = ALU_SLTU;
      FNC_XOR:     op = ALU_XOR;
      FNC_SRL_SRA: begin
        if (alt == FNC7_SRA) op = ALU_SRA;  // Same bit for srai
        else op = ALU_SRL;
      end
      FNC_OR:      op = ALU_OR;
      FNC_AND:     op = ALU_AND;
      default:     op = ALU_ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    alu_sel = ALU_ADD;  // Address and pc adds
    b_sel   = opc_ok;   // Bubble keeps B on the register
    br_un   = 1'b0;
    if (opc_ok) begin
      case (opc)
        OPC_ARI_RTYPE: begin
          b_sel   = 1'b0;
          alu_sel = arith_op(funct3, bit30, 1'b1);
        end
        OPC_ARI_ITYPE: begin
          alu_sel = arith_op(funct3, bit30, 1'b0);
        end
        OPC_BRANCH: begin
          br_un = (funct3 == FNC_BLTU) || (funct3 == FNC_BGEU);
        end
        OPC_LUI: begin
          alu_sel = ALU_PASS_B;  // Immediate straight through
        end
        default: begin
          alu_sel = ALU_ADD;
        end
      endcase
    end
  end

endmodule

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  localparam int XLEN   = 32;  // Instruction word width
  localparam int REG_AW = 5;   // Register index width

  localparam logic [1:0] OPC_LOW = 2'b11;  // Low opcode bits of every 32-bit encoding

  typedef enum logic [4:0] {
    OPC_LOAD      = 5'b00000,
    OPC_ARI_ITYPE = 5'b00100,
    OPC_AUIPC     = 5'b00101,
    OPC_STORE     = 5'b01000,
    OPC_ARI_RTYPE = 5'b01100,
    OPC_LUI       = 5'b01101,
    OPC_BRANCH    = 5'b11000,
    OPC_JALR      = 5'b11001,
    OPC_JAL       = 5'b11011
  } opcode_e;

  // Branch funct3
  localparam logic [2:0] FNC_BEQ  = 3'b000;
  localparam logic [2:0] FNC_BNE  = 3'b001;
  localparam logic [2:0] FNC_BLT  = 3'b100;
  localparam logic [2:0] FNC_BGE  = 3'b101;
  localparam logic [2:0] FNC_BLTU = 3'b110;
  localparam logic [2:0] FNC_BGEU = 3'b111;

  // Load funct3
  localparam logic [2:0] FNC_LB  = 3'b000;
  localparam logic [2:0] FNC_LH  = 3'b001;
  localparam logic [2:0] FNC_LW  = 3'b010;
  localparam logic [2:0] FNC_LBU = 3'b100;
  localparam logic [2:0] FNC_LHU = 3'b101;

  // Arithmetic funct3
  localparam logic [2:0] FNC_ADD_SUB = 3'b000;
  localparam logic [2:0] FNC_SLL     = 3'b001;
  localparam logic [2:0] FNC_SLT     = 3'b010;
  localparam logic [2:0] FNC_SLTU    = 3'b011;
  localparam logic [2:0] FNC_XOR     = 3'b100;
  localparam logic [2:0] FNC_SRL_SRA = 3'b101;
  localparam logic [2:0] FNC_OR      = 3'b110;
  localparam logic [2:0] FNC_AND     = 3'b111;

  localparam logic FNC7_SUB = 1'b1;  // Bit 30 for sub
  localparam logic FNC7_SRA = 1'b1;  // Bit 30 for sra/srai

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10  // LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    PC_RESET = 3'd0,
    PC_JAL   = 3'd1,
    PC_SEQ   = 3'd2,
    PC_ALU   = 3'd3,
    PC_X_SEQ = 3'd4  // X pc + 4 after a wrong taken guess
  } pc_sel_e;

  typedef enum logic [1:0] {WB_MEM = 2'd0, WB_ALU = 2'd1, WB_PC4 = 2'd2} wb_sel_e;

  typedef enum logic [2:0] {
    LX_W  = 3'd0,
    LX_HU = 3'd1,
    LX_H  = 3'd2,
    LX_BU = 3'd3,
    LX_B  = 3'd4
  } ldx_sel_e;

  typedef enum logic [1:0] {FWD_REG = 2'd0, FWD_ALU = 2'd1, FWD_MEM = 2'd2} fwd_sel_e;

  typedef enum logic [1:0] {A_REG = 2'd0, A_PC = 2'd1, A_MEM = 2'd2} a_sel_e;

  localparam logic [XLEN-1:0] BUBBLE_INSTR = '0;  // Low bits 00, never decodes

  function automatic logic instr_ok(input logic [XLEN-1:0] instr);
    return instr[1:0] == OPC_LOW;
  endfunction

  function automatic opcode_e instr_opc(input logic [XLEN-1:0] instr);
    return opcode_e'(instr[6:2]);
  endfunction

  function automatic logic [2:0] instr_funct3(input logic [XLEN-1:0] instr);
    return instr[14:12];
  endfunction

  function automatic logic [REG_AW-1:0] instr_rd(input logic [XLEN-1:0] instr);
    return instr[11:7];
  endfunction

  function automatic logic [REG_AW-1:0] instr_rs1(input logic [XLEN-1:0] instr);
    return instr[19:15];
  endfunction

  function automatic logic [REG_AW-1:0] instr_rs2(input logic [XLEN-1:0] instr);
    return instr[24:20];
  endfunction

endpackage
